// ==== logic/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Rename lanes per cycle
    localparam int LANES     = 3;
    localparam int ARCH_REGS = 32;
    localparam int ROB_DEPTH = 32;
    localparam int ARCH_W    = 5;
    localparam int ROB_W     = 5;
    // One extra bit selects register file or reorder buffer
    localparam int PHYS_W    = 6;

    // ==============================
    // Types
    // ==============================

    typedef logic [ARCH_W-1:0] arch_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;
    // Top bit set means reorder-buffer entry
    typedef logic [PHYS_W-1:0] phys_t;

    // One decoded instruction
    typedef struct packed {
        logic  valid;
        arch_t rs1;
        arch_t rs2;
        arch_t rd;
        logic  rd_we;
    } rename_req_t;

    // One renamed instruction
    typedef struct packed {
        logic  valid;
        phys_t rs1_phys;
        phys_t rs2_phys;
        phys_t rd_phys;
        phys_t old_rd_phys;
    } rename_rsp_t;

    // One retiring instruction
    typedef struct packed {
        logic     valid;
        arch_t    arch;
        rob_idx_t rob_idx;
    } commit_t;

    // One map update from the rename group
    typedef struct packed {
        logic  en;
        arch_t arch;
        phys_t phys;
    } map_write_t;

endpackage

`default_nettype wire

// ==== logic/free_tag_list.sv ====
`default_nettype none

module free_tag_list (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [rename_pkg::LANES-1:0] lane_valid_i,
    input  wire rename_pkg::commit_t        commit_i [rename_pkg::LANES],
    output logic [rename_pkg::LANES-1:0]    grant_o,
    output rename_pkg::rob_idx_t            tag_o [rename_pkg::LANES],
    output logic [2:0]                      ready_o
);

    // Count spans 0 to ROB_DEPTH inclusive
    typedef logic [rename_pkg::ROB_W:0] cnt_t;

    // ==============================
    // State
    // ==============================

    // Circular store of free reorder-buffer indices
    rename_pkg::rob_idx_t store [rename_pkg::ROB_DEPTH];
    // Pointers wrap on their own at 32
    rename_pkg::rob_idx_t rd_ptr;
    rename_pkg::rob_idx_t wr_ptr;
    cnt_t                 count;

    // Per-cycle totals
    logic [1:0]           num_grant;
    logic [1:0]           num_return;
    // Write slot for each committing lane
    rename_pkg::rob_idx_t wr_addr [rename_pkg::LANES];

    // ==============================
    // Grants
    // ==============================

    // k-th valid lane gets the entry k past the read pointer
    always_comb begin : grant_logic
        logic [1:0] slot;
        slot      = '0;
        num_grant = '0;
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            grant_o[i] = 1'b0;
            tag_o[i]   = '0;
            if (lane_valid_i[i]) begin
                // Only the registered count limits grants
                if (cnt_t'(slot) < count) begin
                    grant_o[i] = 1'b1;
                    tag_o[i]   = store[rd_ptr + rename_pkg::rob_idx_t'(slot)];
                    num_grant  = num_grant + 2'd1;
                end
                slot = slot + 2'd1;
            end
        end
    end

    // ==============================
    // Returns
    // ==============================

    // Committed indices land at the write pointer in lane order
    always_comb begin
        num_return = '0;
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            wr_addr[i] = wr_ptr + rename_pkg::rob_idx_t'(num_return);
            if (commit_i[i].valid) begin
                num_return = num_return + 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Every entry free, in index order
            for (int e = 0; e < rename_pkg::ROB_DEPTH; e++) begin
                store[e] <= rename_pkg::rob_idx_t'(e);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= cnt_t'(rename_pkg::ROB_DEPTH);
        end else begin
            for (int i = 0; i < rename_pkg::LANES; i++) begin
                if (commit_i[i].valid) begin
                    store[wr_addr[i]] <= commit_i[i].rob_idx;
                end
            end
            rd_ptr <= rd_ptr + rename_pkg::rob_idx_t'(num_grant);
            wr_ptr <= wr_ptr + rename_pkg::rob_idx_t'(num_return);
            // Net change of returns minus grants
            count  <= count + cnt_t'(num_return) - cnt_t'(num_grant);
        end
    end

    // Thermometer of lanes that can surely be served
    always_comb begin
        if (count >= cnt_t'(3)) begin
            ready_o = 3'b111;
        end else if (count == cnt_t'(2)) begin
            ready_o = 3'b011;
        end else if (count == cnt_t'(1)) begin
            ready_o = 3'b001;
        end else begin
            ready_o = 3'b000;
        end
    end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`default_nettype none

module map_table (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire rename_pkg::rename_req_t req_i [rename_pkg::LANES],
    input  wire rename_pkg::commit_t     commit_i [rename_pkg::LANES],
    input  wire rename_pkg::map_write_t  write_i [rename_pkg::LANES],
    output rename_pkg::phys_t            rs1_map_o [rename_pkg::LANES],
    output rename_pkg::phys_t            rs2_map_o [rename_pkg::LANES],
    output rename_pkg::phys_t            rd_map_o [rename_pkg::LANES]
);

    // ==============================
    // Map storage
    // ==============================

    // Current physical tag of each architectural register
    rename_pkg::phys_t map_q [rename_pkg::ARCH_REGS];

    // ==============================
    // Lookups
    // ==============================

    // Straight from the registered table
    // Same-group forwarding happens downstream
    always_comb begin
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            rs1_map_o[i] = map_q[req_i[i].rs1];
            rs2_map_o[i] = map_q[req_i[i].rs2];
            // Prior mapping of the destination
            rd_map_o[i]  = map_q[req_i[i].rd];
        end
    end

    // ==============================
    // Updates
    // ==============================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity map, every register in the register file
            for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
                map_q[r] <= rename_pkg::phys_t'(r);
            end
        end else begin
            // Commit restores first, lane 0 up
            for (int i = 0; i < rename_pkg::LANES; i++) begin
                // Restore only if the map still names this ROB entry
                if (commit_i[i].valid && (commit_i[i].arch != '0) &&
                    (map_q[commit_i[i].arch] == {1'b1, commit_i[i].rob_idx})) begin
                    map_q[commit_i[i].arch] <= {1'b0, commit_i[i].arch};
                end
            end
            // Rename writes after, so they override commits
            // Later lanes override earlier ones
            for (int i = 0; i < rename_pkg::LANES; i++) begin
                // x0 stays hardwired to tag 0
                if (write_i[i].en && (write_i[i].arch != '0)) begin
                    map_q[write_i[i].arch] <= write_i[i].phys;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_combine.sv ====
`default_nettype none

module rename_combine (
    input  wire rename_pkg::rename_req_t    req_i [rename_pkg::LANES],
    input  wire logic [rename_pkg::LANES-1:0] grant_i,
    input  wire rename_pkg::rob_idx_t       tag_i [rename_pkg::LANES],
    input  wire rename_pkg::phys_t          rs1_map_i [rename_pkg::LANES],
    input  wire rename_pkg::phys_t          rs2_map_i [rename_pkg::LANES],
    input  wire rename_pkg::phys_t          rd_map_i [rename_pkg::LANES],
    output rename_pkg::rename_rsp_t         rsp_o [rename_pkg::LANES],
    output rename_pkg::map_write_t          write_o [rename_pkg::LANES]
);

    // Lane produces a new mapping visible to later lanes
    logic [rename_pkg::LANES-1:0] fwd;
    // ROB tag of each lane in physical form
    rename_pkg::phys_t            new_tag [rename_pkg::LANES];

    always_comb begin
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            new_tag[i] = {1'b1, tag_i[i]};
            // Writes to x0 and lanes without rd never forward
            fwd[i]     = grant_i[i] && req_i[i].rd_we && (req_i[i].rd != '0);
        end
    end

    // ==============================
    // Intra-group bypass
    // ==============================

    always_comb begin : result_logic
        rename_pkg::phys_t rs1_sel;
        rename_pkg::phys_t rs2_sel;
        rename_pkg::phys_t old_sel;
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            // Default to the table
            rs1_sel = rs1_map_i[i];
            rs2_sel = rs2_map_i[i];
            old_sel = rd_map_i[i];
            // Scan older lanes oldest first so the newest match wins
            for (int j = 0; j < i; j++) begin
                if (fwd[j]) begin
                    if (req_i[j].rd == req_i[i].rs1) begin
                        rs1_sel = new_tag[j];
                    end
                    if (req_i[j].rd == req_i[i].rs2) begin
                        rs2_sel = new_tag[j];
                    end
                    if (req_i[j].rd == req_i[i].rd) begin
                        old_sel = new_tag[j];
                    end
                end
            end
            // Ungranted lane reads as all zero
            rsp_o[i] = '0;
            if (grant_i[i]) begin
                rsp_o[i].valid       = 1'b1;
                rsp_o[i].rs1_phys    = rs1_sel;
                rsp_o[i].rs2_phys    = rs2_sel;
                rsp_o[i].rd_phys     = new_tag[i];
                rsp_o[i].old_rd_phys = old_sel;
            end
        end
    end

    // ==============================
    // Map-write requests
    // ==============================

    // Lane order is kept so the table lets later lanes win
    always_comb begin
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            write_o[i] = '0;
            if (fwd[i]) begin
                write_o[i].en   = 1'b1;
                write_o[i].arch = req_i[i].rd;
                write_o[i].phys = new_tag[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/register_rename.sv ====
`default_nettype none

module register_rename (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire rename_pkg::rename_req_t req_i [rename_pkg::LANES],
    input  wire rename_pkg::commit_t     commit_i [rename_pkg::LANES],
    output rename_pkg::rename_rsp_t      rsp_o [rename_pkg::LANES],
    output logic [2:0]                   rename_ready_o
);

    // Lane strobes toward the free list
    logic [rename_pkg::LANES-1:0] lane_valid;
    // Free list results
    logic [rename_pkg::LANES-1:0] grant;
    rename_pkg::rob_idx_t         tag [rename_pkg::LANES];
    // Registered mappings
    rename_pkg::phys_t            rs1_map [rename_pkg::LANES];
    rename_pkg::phys_t            rs2_map [rename_pkg::LANES];
    rename_pkg::phys_t            rd_map [rename_pkg::LANES];
    // Updates fed back into the table
    rename_pkg::map_write_t       map_write [rename_pkg::LANES];

    always_comb begin
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            lane_valid[i] = req_i[i].valid;
        end
    end

    // ==============================
    // Tag allocation
    // ==============================

    free_tag_list u_free_tag_list (
        .clk          (clk),
        .reset        (reset),
        .lane_valid_i (lane_valid),
        .commit_i     (commit_i),
        .grant_o      (grant),
        .tag_o        (tag),
        .ready_o      (rename_ready_o)
    );

    // ==============================
    // Map and bypass
    // ==============================

    map_table u_map_table (
        .clk       (clk),
        .reset     (reset),
        .req_i     (req_i),
        .commit_i  (commit_i),
        .write_i   (map_write),
        .rs1_map_o (rs1_map),
        .rs2_map_o (rs2_map),
        .rd_map_o  (rd_map)
    );

    rename_combine u_rename_combine (
        .req_i     (req_i),
        .grant_i   (grant),
        .tag_i     (tag),
        .rs1_map_i (rs1_map),
        .rs2_map_i (rs2_map),
        .rd_map_i  (rd_map),
        .rsp_o     (rsp_o),
        .write_o   (map_write)
    );

endmodule

`default_nettype wire

// ==== verification/rename_checker.sv ====
`default_nettype none

module rename_checker (
    input wire logic                           clk,
    input wire logic                           reset,
    input wire rename_pkg::phys_t              map_zero_i,
    input wire logic [rename_pkg::ROB_W:0]     count_i,
    input wire logic [rename_pkg::LANES-1:0]   grant_i
);

    // Assertion failures so far
    int fail_count = 0;

    // x0 stays pinned to the register file
    zero_map: assert property (@(posedge clk) disable iff (!reset) map_zero_i == '0)
        else begin
            $error("map entry 0 left tag 0");
            fail_count++;
        end

    // Never more free tags than ROB entries
    count_max: assert property (@(posedge clk) disable iff (!reset) count_i <= 6'd32)
        else begin
            $error("free count above ROB depth");
            fail_count++;
        end

    // Empty free list hands out nothing
    no_grant_empty: assert property (@(posedge clk) disable iff (!reset)
        (count_i == '0) |-> (grant_i == '0))
        else begin
            $error("grant while free list empty");
            fail_count++;
        end

endmodule

// ==============================
// Attachment to the DUT
// ==============================

// Map entry from the table, count and grants from the free list
bind register_rename rename_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .map_zero_i (u_map_table.map_q[0]),
    .count_i    (u_free_tag_list.count),
    .grant_i    (grant)
);

`default_nettype wire

// ==== verification/rename_monitor.sv ====
`default_nettype none

module rename_monitor (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire rename_pkg::rename_req_t req_i [rename_pkg::LANES],
    input  wire rename_pkg::commit_t     commit_i [rename_pkg::LANES],
    input  wire rename_pkg::rename_rsp_t rsp_i [rename_pkg::LANES],
    input  wire logic [2:0]              ready_i,
    output int                           checks_o,
    output int                           errors_o
);

    typedef rename_pkg::rename_rsp_t [rename_pkg::LANES-1:0] rsp_vec_t;

    // ==============================
    // Reference state
    // ==============================

    rename_pkg::phys_t    ref_map [rename_pkg::ARCH_REGS];
    // Free ROB indices, oldest at the front
    rename_pkg::rob_idx_t ref_free [$];
    int                   n_checks = 0;
    int                   n_errors = 0;

    assign checks_o = n_checks;
    assign errors_o = n_errors;

    // Lanes walk a private copy of the map one after another
    function automatic rsp_vec_t predict_rsp();
        rsp_vec_t          r;
        rename_pkg::phys_t grp [rename_pkg::ARCH_REGS];
        int                k;
        r   = '0;
        k   = 0;
        grp = ref_map;
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            if (req_i[i].valid) begin
                if (k < ref_free.size()) begin
                    r[i].valid       = 1'b1;
                    r[i].rs1_phys    = grp[req_i[i].rs1];
                    r[i].rs2_phys    = grp[req_i[i].rs2];
                    r[i].old_rd_phys = grp[req_i[i].rd];
                    r[i].rd_phys     = {1'b1, ref_free[k]};
                    if (req_i[i].rd_we && req_i[i].rd != '0) begin
                        grp[req_i[i].rd] = r[i].rd_phys;
                    end
                end
                k++;
            end
        end
        return r;
    endfunction

    function automatic logic [2:0] expected_ready(input int free_n);
        if (free_n >= 3) begin
            return 3'b111;
        end else if (free_n == 2) begin
            return 3'b011;
        end else if (free_n == 1) begin
            return 3'b001;
        end
        return 3'b000;
    endfunction

    // ==============================
    // Compare, then step the model
    // ==============================

    // Mid-cycle sampling, outputs settled
    always @(negedge clk) begin : compare
        rsp_vec_t   exp_rsp;
        logic [2:0] exp_ready;
        int         granted;
        if (!reset) begin
            for (int a = 0; a < rename_pkg::ARCH_REGS; a++) begin
                ref_map[a] = rename_pkg::phys_t'(a);
            end
            ref_free.delete();
            for (int e = 0; e < rename_pkg::ROB_DEPTH; e++) begin
                ref_free.push_back(rename_pkg::rob_idx_t'(e));
            end
        end else begin
            exp_rsp   = predict_rsp();
            exp_ready = expected_ready(ref_free.size());
            n_checks++;
            for (int i = 0; i < rename_pkg::LANES; i++) begin
                if (rsp_i[i] !== exp_rsp[i]) begin
                    n_errors++;
                    $display("error: rsp_o[%0d] expected %h got %h at %0t",
                             i, exp_rsp[i], rsp_i[i], $time);
                end
            end
            if (ready_i !== exp_ready) begin
                n_errors++;
                $display("error: rename_ready_o expected %h got %h at %0t",
                         exp_ready, ready_i, $time);
            end
            // Commit restores first
            for (int i = 0; i < rename_pkg::LANES; i++) begin
                if (commit_i[i].valid && commit_i[i].arch != '0 &&
                    ref_map[commit_i[i].arch] == {1'b1, commit_i[i].rob_idx}) begin
                    ref_map[commit_i[i].arch] = {1'b0, commit_i[i].arch};
                end
            end
            // New mappings override, later lanes last
            granted = 0;
            for (int i = 0; i < rename_pkg::LANES; i++) begin
                if (exp_rsp[i].valid) begin
                    granted++;
                    if (req_i[i].rd_we && req_i[i].rd != '0) begin
                        ref_map[req_i[i].rd] = exp_rsp[i].rd_phys;
                    end
                end
            end
            for (int g = 0; g < granted; g++) begin
                ref_free.delete(0);
            end
            for (int i = 0; i < rename_pkg::LANES; i++) begin
                if (commit_i[i].valid) begin
                    ref_free.push_back(commit_i[i].rob_idx);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/rename_tb.sv ====
`default_nettype none

module rename_tb;

    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_CYCLES = 300;
    // Per test reset, drain and report, plus directed and random cycles
    localparam int TOTAL_CYCLES  = 6 * (RESET_CYCLES + 14) + 50 + RANDOM_CYCLES;
    localparam rename_pkg::rename_req_t NO_REQ = '0;

    logic                    clk = 1'b0;
    logic                    reset = 1'b0;
    rename_pkg::rename_req_t req [rename_pkg::LANES] = '{default: '0};
    rename_pkg::commit_t     commit [rename_pkg::LANES] = '{default: '0};
    rename_pkg::rename_rsp_t rsp [rename_pkg::LANES];
    logic [2:0]              ready;

    // Renamed instructions waiting to retire, oldest first
    rename_pkg::commit_t     pending [$];
    integer                  seed = 32'h6ac0_6835;
    int                      checks;
    int                      errors;
    int                      test_num = 0;
    int                      failed_tests = 0;
    int                      mark_checks;
    int                      mark_errors;
    int                      mark_asserts;

    always #5 clk = ~clk;

    register_rename dut (
        .clk            (clk),
        .reset          (reset),
        .req_i          (req),
        .commit_i       (commit),
        .rsp_o          (rsp),
        .rename_ready_o (ready)
    );

    rename_monitor u_monitor (
        .clk      (clk),
        .reset    (reset),
        .req_i    (req),
        .commit_i (commit),
        .rsp_i    (rsp),
        .ready_i  (ready),
        .checks_o (checks),
        .errors_o (errors)
    );

    function automatic int assert_failures();
        return dut.u_checker.fail_count;
    endfunction

    function automatic rename_pkg::rename_req_t make_req(input logic v, input int rs1,
                                                         input int rs2, input int rd,
                                                         input logic we);
        rename_pkg::rename_req_t r;
        r.valid = v;
        r.rs1   = rename_pkg::arch_t'(rs1);
        r.rs2   = rename_pkg::arch_t'(rs2);
        r.rd    = rename_pkg::arch_t'(rd);
        r.rd_we = we;
        return r;
    endfunction

    task automatic random_req(output rename_pkg::rename_req_t r);
        r.valid = ($random(seed) & 3) != 0;
        r.rs1   = rename_pkg::arch_t'($random(seed));
        r.rs2   = rename_pkg::arch_t'($random(seed));
        r.rd    = rename_pkg::arch_t'($random(seed));
        r.rd_we = ($random(seed) & 1) != 0;
    endtask

    // ==============================
    // Cycle driver
    // ==============================

    // Retires up to ncommit oldest entries alongside the new group
    task automatic run_cycle(input rename_pkg::rename_req_t l0,
                             input rename_pkg::rename_req_t l1,
                             input rename_pkg::rename_req_t l2, input int ncommit);
        rename_pkg::commit_t c [rename_pkg::LANES];
        rename_pkg::commit_t rec;
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            c[i] = '0;
            if (i < ncommit && pending.size() > 0) begin
                c[i] = pending.pop_front();
            end
        end
        @(posedge clk);
        req[0] <= l0;
        req[1] <= l1;
        req[2] <= l2;
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            commit[i] <= c[i];
        end
        @(negedge clk);
        // Granted lanes join the retire queue in allocation order
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            if (rsp[i].valid) begin
                rec.valid   = 1'b1;
                rec.arch    = req[i].rd_we ? req[i].rd : '0;
                rec.rob_idx = rsp[i].rd_phys[rename_pkg::ROB_W-1:0];
                pending.push_back(rec);
            end
        end
    endtask

    task automatic start_test();
        pending.delete();
        @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < rename_pkg::LANES; i++) begin
            req[i]    <= '0;
            commit[i] <= '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset        <= 1'b1;
        test_num     = test_num + 1;
        mark_checks  = checks;
        mark_errors  = errors;
        mark_asserts = assert_failures();
    endtask

    // Retire everything left, then report
    task automatic end_test(input string name);
        int d_err;
        int d_asr;
        while (pending.size() > 0) begin
            run_cycle(NO_REQ, NO_REQ, NO_REQ, 3);
        end
        run_cycle(NO_REQ, NO_REQ, NO_REQ, 0);
        @(posedge clk);
        d_err = errors - mark_errors;
        d_asr = assert_failures() - mark_asserts;
        if (d_err != 0 || d_asr != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d cycles checked, %0d mismatches, %0d assertion failures",
                 test_num, name, checks - mark_checks, d_err, d_asr);
    endtask

    // ==============================
    // Tests
    // ==============================

    initial begin : stimulus
        rename_pkg::rename_req_t l0;
        rename_pkg::rename_req_t l1;
        rename_pkg::rename_req_t l2;
        start_test();
        // Sources only, no destination writes
        for (int k = 0; k < 11; k++) begin
            run_cycle(make_req(1'b1, 3 * k, 31 - 3 * k, 0, 1'b0),
                      make_req(1'b1, 3 * k + 1, 30 - 3 * k, 0, 1'b0),
                      make_req(1'b1, 3 * k + 2, 29 - 3 * k, 0, 1'b0), 3);
        end
        end_test("reset identity");

        start_test();
        run_cycle(make_req(1'b1, 1, 2, 5, 1'b1), NO_REQ, NO_REQ, 0);
        run_cycle(make_req(1'b1, 5, 5, 5, 1'b1), NO_REQ, NO_REQ, 0);
        end_test("single rename");

        start_test();
        run_cycle(make_req(1'b1, 1, 2, 3, 1'b1), make_req(1'b1, 3, 1, 3, 1'b1),
                  make_req(1'b1, 3, 3, 3, 1'b1), 0);
        // x0 destinations and lanes without rd_we must not forward
        run_cycle(make_req(1'b1, 4, 4, 0, 1'b1), make_req(1'b1, 0, 4, 0, 1'b1),
                  make_req(1'b1, 0, 0, 0, 1'b0), 0);
        run_cycle(make_req(1'b1, 8, 9, 7, 1'b0), make_req(1'b1, 7, 8, 7, 1'b1),
                  make_req(1'b1, 7, 9, 8, 1'b1), 0);
        end_test("intra-group bypass");

        start_test();
        for (int k = 0; k < 10; k++) begin
            run_cycle(make_req(1'b1, k, k + 1, k + 2, 1'b1),
                      make_req(1'b1, k + 3, k, k + 4, 1'b1),
                      make_req(1'b1, k + 5, k + 2, k + 6, 1'b1), 0);
        end
        // Two left, then one, then none
        run_cycle(make_req(1'b1, 1, 2, 3, 1'b1), NO_REQ, NO_REQ, 0);
        run_cycle(NO_REQ, make_req(1'b1, 3, 4, 5, 1'b1), make_req(1'b1, 5, 6, 7, 1'b1), 0);
        run_cycle(make_req(1'b1, 7, 8, 9, 1'b1), make_req(1'b1, 9, 1, 2, 1'b1),
                  make_req(1'b1, 2, 3, 4, 1'b1), 0);
        end_test("free list exhaustion");

        start_test();
        run_cycle(make_req(1'b1, 0, 0, 6, 1'b1), NO_REQ, NO_REQ, 0);
        run_cycle(NO_REQ, NO_REQ, NO_REQ, 1);
        // x6 back in the register file
        run_cycle(make_req(1'b1, 6, 0, 7, 1'b1), NO_REQ, NO_REQ, 0);
        run_cycle(make_req(1'b1, 7, 0, 7, 1'b1), NO_REQ, NO_REQ, 0);
        // Older x7 retires while the newer one holds the map
        run_cycle(make_req(1'b1, 7, 6, 9, 1'b0), NO_REQ, NO_REQ, 1);
        run_cycle(make_req(1'b1, 7, 6, 9, 1'b0), NO_REQ, NO_REQ, 0);
        // Wrap the free list so returned indices come around again
        for (int k = 0; k < 12; k++) begin
            run_cycle(make_req(1'b1, k, 2 * k, k + 1, 1'b1),
                      make_req(1'b1, k + 1, k, 3 * k, 1'b1),
                      make_req(1'b1, 3 * k, k + 1, k + 2, 1'b0), 3);
        end
        end_test("commit restore");

        start_test();
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            random_req(l0);
            random_req(l1);
            random_req(l2);
            run_cycle(l0, l1, l2, $random(seed) & 3);
        end
        end_test("random traffic");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assert fails",
                 test_num, failed_tests, checks, errors, assert_failures());
        if (failed_tests == 0 && errors == 0 && assert_failures() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Twice the expected run length
    initial begin : watchdog
        #(TOTAL_CYCLES * 10 * 2);
        $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES * 2);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/rename_pkg.sv
logic/free_tag_list.sv
logic/map_table.sv
logic/rename_combine.sv
logic/register_rename.sv
verification/rename_checker.sv
verification/rename_monitor.sv
verification/rename_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rename_tb -f project.f

# The simulation passes only if the pass line shows up in its output
./obj_dir/Vrename_tb +verilator+error+limit+1000 | tee /dev/stderr | grep -qx 'Test OK'
